// ==== logic/uio_pkg.sv ====
// host command port definitions
// word width, command codes and the decoded host word

package uio_pkg;

	// host word and command byte widths
	localparam int UIO_W = 16;
	localparam int CMD_W = 8;

	// commands kept in this slice
	localparam logic [CMD_W-1:0] CMD_LED = 8'h25;
	localparam logic [CMD_W-1:0] CMD_VOL = 8'h26;

	// first word of a transaction, low byte is the command
	typedef struct packed {
		logic [UIO_W-CMD_W-1:0] unused;
		logic [CMD_W-1:0]       code;
	} uio_cmd_t;

	// parameter of 0x25
	typedef struct packed {
		logic [7:0] overtake;
		logic [7:0] state;
	} uio_led_t;

	// parameter of 0x26, mute over a 4 bit right shift
	typedef struct packed {
		logic [UIO_W-6:0] unused;
		logic             mute;
		logic [3:0]       shift;
	} uio_vol_t;

	typedef union packed {
		uio_cmd_t cmd;
		uio_led_t led;
		uio_vol_t vol;
	} uio_word_t;

endpackage

// ==== logic/audio_pkg.sv ====
// audio mixer definitions
// sample width default, attenuation layout, mix modes

package audio_pkg;

	localparam int SAMPLE_W_DEF = 16;

	// attenuation field: mute on top, shift amount below
	localparam int ATT_W       = 5;
	localparam int ATT_MUTE    = ATT_W - 1;
	localparam int ATT_SHIFT_W = 4;

	// stereo cross-feed modes
	localparam int MIX_W = 2;

	localparam logic [MIX_W-1:0] MIX_NONE = 2'd0;
	localparam logic [MIX_W-1:0] MIX_25   = 2'd1;
	localparam logic [MIX_W-1:0] MIX_50   = 2'd2;
	localparam logic [MIX_W-1:0] MIX_MONO = 2'd3;

endpackage

// ==== logic/uio_cmd_decoder.sv ====
// host command decoder
// strobe edge, command/parameter parsing, LED and volume registers

`timescale 1ns/100ps

module uio_cmd_decoder (
	input  logic                        clk,
	input  logic                        resetd,
	input  logic                        i_io_uio,
	input  logic                        i_io_strobe,
	input  uio_pkg::uio_word_t          i_io_din,
	input  logic                        i_led_user,
	input  logic [1:0]                  i_led_power,
	input  logic [1:0]                  i_led_disk,
	input  logic                        i_pll_locked,
	output logic [audio_pkg::ATT_W-1:0] o_vol_att,
	output logic [7:0]                  o_led
);
	import uio_pkg::*;

	logic             old_strobe;
	logic             strobe_rise;
	logic             has_cmd;
	logic [CMD_W-1:0] cmd;
	logic [7:0]       led_overtake;
	logic [7:0]       led_state;
	logic             req_power;
	logic             req_disk;
	logic [7:0]       led_default;

	// a word counts on the rising edge of the strobe level
	assign strobe_rise = i_io_strobe & ~old_strobe;

	//////////////////////////////
	// command parsing
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			old_strobe   <= 1'b0;
			has_cmd      <= 1'b0;
			cmd          <= '0;
			led_overtake <= '0;
			led_state    <= '0;
			o_vol_att    <= '0;
		end else begin
			old_strobe <= i_io_strobe;

			// deselect closes the transaction
			if (!i_io_uio) begin
				has_cmd <= 1'b0;
				cmd     <= '0;
			end else if (strobe_rise) begin
				if (!has_cmd) begin
					has_cmd <= 1'b1;
					cmd     <= i_io_din.cmd.code;
				end else begin
					// every parameter word rewrites the register
					if (cmd == CMD_LED) begin
						led_overtake <= i_io_din.led.overtake;
						led_state    <= i_io_din.led.state;
					end
					if (cmd == CMD_VOL)
						o_vol_att <= {i_io_din.vol.mute, i_io_din.vol.shift};
				end
			end
		end
	end

	//////////////////////////////
	// main board LED byte
	//////////////////////////////

	// core requests
	assign req_power = i_led_power[1] & ~i_led_power[0];
	assign req_disk  = i_led_disk[1] ? ~i_led_disk[0] : i_led_disk[0];

	// odd bits stay dark by default
	assign led_default = {1'b0, i_pll_locked, 1'b0, req_power,
	                      1'b0, req_disk, 1'b0, i_led_user};

	// host overtakes per bit
	assign o_led = (led_overtake & led_state) | (~led_overtake & led_default);

endmodule

// ==== logic/sample_deglitch.sv ====
// sample glitch filter
// passes a sample once it stayed the same over consecutive cycles

`timescale 1ns/100ps

module sample_deglitch #(
	parameter int SAMPLE_W = 16
) (
	input  logic                clk,
	input  logic                resetd,
	input  logic [SAMPLE_W-1:0] i_sample,
	output logic [SAMPLE_W-1:0] o_sample
);

	// history, d1 newest, d3 oldest
	logic [SAMPLE_W-1:0] d1;
	logic [SAMPLE_W-1:0] d2;
	logic [SAMPLE_W-1:0] d3;

	always_ff @(posedge clk) begin
		if (resetd) begin
			d1       <= '0;
			d2       <= '0;
			d3       <= '0;
			o_sample <= '0;
		end else begin
			d1 <= i_sample;
			d2 <= d1;
			d3 <= d2;
			// a value toggling every cycle never matches its predecessor
			if (d2 == d3)
				o_sample <= d2;
		end
	end

endmodule

// ==== logic/audio_mix_channel.sv ====
// one mixer channel
// sign handling, host add, cross-feed, attenuation and clamp

`timescale 1ns/100ps

module audio_mix_channel #(
	parameter int SAMPLE_W = 16
) (
	input  logic                        clk,
	input  logic                        resetd,
	input  logic [audio_pkg::ATT_W-1:0] i_vol_att,
	input  logic [audio_pkg::MIX_W-1:0] i_mix,
	input  logic                        i_is_signed,
	input  logic [SAMPLE_W-1:0]         i_core,
	input  logic [SAMPLE_W-1:0]         i_host,
	input  logic [SAMPLE_W-1:0]         i_pre,
	output logic [SAMPLE_W-1:0]         o_pre,
	output logic [SAMPLE_W-1:0]         o_out
);
	import audio_pkg::*;

	// one guard bit over the sample
	logic signed [SAMPLE_W:0] host_ext;
	logic signed [SAMPLE_W:0] pre_ext;
	logic signed [SAMPLE_W:0] a1;
	logic signed [SAMPLE_W:0] a2;
	logic signed [SAMPLE_W:0] a3;
	logic signed [SAMPLE_W:0] a4;
	logic [ATT_SHIFT_W-1:0]   att_shift;

	assign host_ext  = {i_host[SAMPLE_W-1], i_host};
	assign pre_ext   = {i_pre[SAMPLE_W-1], i_pre};
	assign att_shift = i_vol_att[ATT_SHIFT_W-1:0];

	always_ff @(posedge clk) begin
		if (resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
			o_pre <= '0;
			o_out <= '0;
		end else begin
			// unsigned core is halved so it fits the signed range
			if (i_is_signed)
				a1 <= {i_core[SAMPLE_W-1], i_core};
			else
				a1 <= {2'b00, i_core[SAMPLE_W-1:1]};

			a2    <= a1 + host_ext;
			o_pre <= a2[SAMPLE_W:1];

			// cross-feed from the other channel
			case (i_mix)
				MIX_NONE: a3 <= a2;
				MIX_25:   a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				MIX_50:   a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				MIX_MONO: a3 <= (a2 >>> 1) + pre_ext;
				default:  a3 <= a2;
			endcase

			// volume
			if (i_vol_att[ATT_MUTE])
				a4 <= '0;
			else
				a4 <= a3 >>> att_shift;

			// saturate when the guard bit disagrees with the sign
			if (a4[SAMPLE_W] != a4[SAMPLE_W-1])
				o_out <= {a4[SAMPLE_W], {(SAMPLE_W-1){~a4[SAMPLE_W]}}};
			else
				o_out <= a4[SAMPLE_W-1:0];
		end
	end

endmodule

// ==== logic/hps_audio_top.sv ====
// host command port and stereo mixer top level
// decoder, two glitch filters, two cross-wired mixer channels

`timescale 1ns/100ps

module hps_audio_top #(
	parameter int SAMPLE_W = audio_pkg::SAMPLE_W_DEF
) (
	input  logic                        clk,
	input  logic                        resetd,
	input  logic                        i_io_uio,
	input  logic                        i_io_strobe,
	input  logic [uio_pkg::UIO_W-1:0]   i_io_din,
	input  logic                        i_led_user,
	input  logic [1:0]                  i_led_power,
	input  logic [1:0]                  i_led_disk,
	input  logic                        i_pll_locked,
	input  logic [SAMPLE_W-1:0]         i_core_l,
	input  logic [SAMPLE_W-1:0]         i_core_r,
	input  logic [SAMPLE_W-1:0]         i_host_l,
	input  logic [SAMPLE_W-1:0]         i_host_r,
	input  logic [audio_pkg::MIX_W-1:0] i_mix,
	input  logic                        i_is_signed,
	output logic [SAMPLE_W-1:0]         o_audio_l,
	output logic [SAMPLE_W-1:0]         o_audio_r,
	output logic [7:0]                  o_led
);
	import audio_pkg::*;

	logic [ATT_W-1:0]    vol_att;
	logic [SAMPLE_W-1:0] core_l_st;
	logic [SAMPLE_W-1:0] core_r_st;
	logic [SAMPLE_W-1:0] pre_l;
	logic [SAMPLE_W-1:0] pre_r;

	uio_cmd_decoder i_cmd_dec (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_uio     (i_io_uio),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_pll_locked (i_pll_locked),
		.o_vol_att    (vol_att),
		.o_led        (o_led)
	);

	//////////////////////////////
	// left channel
	//////////////////////////////

	sample_deglitch #(.SAMPLE_W(SAMPLE_W)) i_deglitch_l (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core_l),
		.o_sample (core_l_st)
	);

	audio_mix_channel #(.SAMPLE_W(SAMPLE_W)) i_chan_l (
		.clk         (clk),
		.resetd      (resetd),
		.i_vol_att   (vol_att),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_core      (core_l_st),
		.i_host      (i_host_l),
		.i_pre       (pre_r),
		.o_pre       (pre_l),
		.o_out       (o_audio_l)
	);

	//////////////////////////////
	// right channel
	//////////////////////////////

	sample_deglitch #(.SAMPLE_W(SAMPLE_W)) i_deglitch_r (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (i_core_r),
		.o_sample (core_r_st)
	);

	// pre values cross over between channels
	audio_mix_channel #(.SAMPLE_W(SAMPLE_W)) i_chan_r (
		.clk         (clk),
		.resetd      (resetd),
		.i_vol_att   (vol_att),
		.i_mix       (i_mix),
		.i_is_signed (i_is_signed),
		.i_core      (core_r_st),
		.i_host      (i_host_r),
		.i_pre       (pre_l),
		.o_pre       (pre_r),
		.o_out       (o_audio_r)
	);

endmodule

// ==== sim/tb_mix_model.svh ====
// reference model of the LED byte and the mixer arithmetic
// whole integer math with floor shifts, clamped at the end

`ifndef TB_MIX_MODEL_SVH
`define TB_MIX_MODEL_SVH

// host bit where overtaken, core request pattern elsewhere
function automatic logic [7:0] led_byte(input uio_word_t setting, input logic user,
	input logic [1:0] power, input logic [1:0] disk, input logic pll);
	logic [7:0] pattern;
	pattern = 8'h00;
	pattern[6] = pll;
	pattern[4] = power[1] && !power[0];
	// disk request flips when bit 1 is set
	pattern[2] = disk[1] ^ disk[0];
	pattern[0] = user;
	for (int i = 0; i < 8; i++)
		if (setting.led.overtake[i])
			pattern[i] = setting.led.state[i];
	return pattern;
endfunction

// core level plus signed host sample, unsigned core halved
function automatic int channel_sum(input logic [SAMPLE_W-1:0] core,
	input logic [SAMPLE_W-1:0] host, input logic is_signed);
	int level;
	int host_level;
	if (is_signed)
		level = $signed(core);
	else
		level = core / 2;
	host_level = $signed(host);
	return level + host_level;
endfunction

function automatic logic [SAMPLE_W-1:0] channel_output(input logic [SAMPLE_W-1:0] core,
	input logic [SAMPLE_W-1:0] host, input logic [SAMPLE_W-1:0] other_core,
	input logic [SAMPLE_W-1:0] other_host, input logic [MIX_W-1:0] mode,
	input logic is_signed, input uio_word_t vol);
	int acc;
	int other_pre;
	int v;
	int lim;
	acc       = channel_sum(core, host, is_signed);
	other_pre = channel_sum(other_core, other_host, is_signed) >>> 1;
	case (mode)
		MIX_25:   v = acc - (acc >>> 3) + (other_pre >>> 2);
		MIX_50:   v = acc - (acc >>> 2) + (other_pre >>> 1);
		MIX_MONO: v = (acc >>> 1) + other_pre;
		default:  v = acc;
	endcase
	if (vol.vol.mute)
		v = 0;
	else
		v = v >>> vol.vol.shift;
	// signed sample range
	lim = 1 << (SAMPLE_W - 1);
	if (v >= lim)
		v = lim - 1;
	else if (v < -lim)
		v = -lim;
	return v[SAMPLE_W-1:0];
endfunction

`endif

// ==== sim/tb_hps_audio.sv ====
// testbench for the host command port and stereo mixer
// seeded random stimulus checked against the reference model

`timescale 1ns/100ps

module tb_hps_audio;
	import uio_pkg::*;
	import audio_pkg::*;

	localparam int SAMPLE_W   = SAMPLE_W_DEF;
	localparam int CLK_PERIOD = 8;
	localparam int HOLD       = 16;
	localparam int N_RAND     = 6;
	localparam logic [31:0] SEED = 32'h5462a342;
	// twice the rough cycle count of all tests
	localparam int TIMEOUT = 2 * (24 + 8 * N_RAND + (N_RAND + 3) * 24
		+ 8 * (N_RAND + 3) * (HOLD + 2) + 4 * (2 * HOLD + 24));

	logic                clk = 1'b0;
	logic                resetd, io_uio, io_strobe, led_user, pll_locked, is_signed;
	logic [UIO_W-1:0]    io_din;
	logic [1:0]          led_power, led_disk;
	logic [MIX_W-1:0]    mix;
	logic [SAMPLE_W-1:0] core_l, core_r, host_l, host_r, audio_l, audio_r;
	logic [7:0]          led;
	uio_word_t           led_set, vol_set;
	int                  cycles = 0;
	int                  test_checks, test_errors, total_checks, total_errors, tests_run;

	always #(CLK_PERIOD / 2) clk = ~clk;

	hps_audio_top #(.SAMPLE_W(SAMPLE_W)) i_hps_audio_top (
		.clk          (clk),
		.resetd       (resetd),
		.i_io_uio     (io_uio),
		.i_io_strobe  (io_strobe),
		.i_io_din     (io_din),
		.i_led_user   (led_user),
		.i_led_power  (led_power),
		.i_led_disk   (led_disk),
		.i_pll_locked (pll_locked),
		.i_core_l     (core_l),
		.i_core_r     (core_r),
		.i_host_l     (host_l),
		.i_host_r     (host_r),
		.i_mix        (mix),
		.i_is_signed  (is_signed),
		.o_audio_l    (audio_l),
		.o_audio_r    (audio_r),
		.o_led        (led)
	);

	`include "tb_mix_model.svh"

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout after %0d cycles, test sequence did not complete", cycles);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		test_checks++;
		if (expected !== actual) begin
			test_errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// one counted word with the strobe high for a cycle
	task automatic send_word(input uio_word_t w);
		@(negedge clk);
		io_din    = w;
		io_strobe = 1'b1;
		@(negedge clk);
		io_strobe = 1'b0;
	endtask

	task automatic send_command(input logic [CMD_W-1:0] code, input uio_word_t param);
		uio_word_t w;
		w          = '0;
		w.cmd.code = code;
		@(negedge clk);
		io_uio = 1'b1;
		send_word(w);
		send_word(param);
		io_uio = 1'b0;
	endtask

	function automatic logic [SAMPLE_W-1:0] random_sample();
		logic [31:0] r;
		r = $urandom;
		return r[SAMPLE_W-1:0];
	endfunction

	task automatic randomize_core_leds();
		logic [31:0] r;
		r          = $urandom;
		led_user   = r[0];
		led_power  = r[2:1];
		led_disk   = r[4:3];
		pll_locked = r[5];
	endtask

	// drive samples and compare both channels once settled
	task automatic hold_and_check(input string name,
		input logic [SAMPLE_W-1:0] cl, cr, hl, hr);
		@(negedge clk);
		core_l = cl;
		core_r = cr;
		host_l = hl;
		host_r = hr;
		repeat (HOLD) @(negedge clk);
		check(name, channel_output(cl, hl, cr, hr, mix, is_signed, vol_set), audio_l);
		check(name, channel_output(cr, hr, cl, hl, mix, is_signed, vol_set), audio_r);
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		uio_word_t           w;
		logic [31:0]         r;
		logic [SAMPLE_W-1:0] s_max, s_min, a_l, a_r, exp_l, exp_r;
		int                  n;

		r = $urandom(SEED);
		resetd    = 1'b1;
		io_uio    = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		mix       = MIX_NONE;
		is_signed = 1'b1;
		core_l    = '0;
		core_r    = '0;
		host_l    = '0;
		host_r    = '0;
		led_set   = '0;
		vol_set   = '0;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		tests_run    = 0;
		randomize_core_leds();
		s_max = {1'b0, {(SAMPLE_W - 1){1'b1}}};
		s_min = ~s_max;
		repeat (8) @(negedge clk);
		resetd = 1'b0;

		@(negedge clk);
		check("reset_state",
			led_byte(led_set, led_user, led_power, led_disk, pll_locked), led);
		// outputs come out of reset cleared
		check("reset_state", 0, audio_l);
		check("reset_state", 0, audio_r);
		hold_and_check("reset_state", '0, '0, '0, '0);
		end_test("reset_state");

		// LED overtake and strobes while deselected
		@(negedge clk);
		io_uio     = 1'b1;
		w          = '0;
		w.cmd.code = CMD_LED;
		send_word(w);
		for (int i = 0; i < 2 * N_RAND; i++) begin
			r = $urandom;
			randomize_core_leds();
			send_word(r[UIO_W-1:0]);
			led_set = r[UIO_W-1:0];
			check("led_cmd",
				led_byte(led_set, led_user, led_power, led_disk, pll_locked), led);
		end
		io_uio = 1'b0;
		for (int i = 0; i < N_RAND; i++) begin
			r = $urandom;
			send_word(r[UIO_W-1:0]);
			check("led_cmd",
				led_byte(led_set, led_user, led_power, led_disk, pll_locked), led);
		end
		end_test("led_cmd");

		// last three settings are muted
		for (int i = 0; i < N_RAND + 3; i++) begin
			r           = $urandom;
			w           = '0;
			w.vol.shift = r[3:0];
			w.vol.mute  = (i >= N_RAND);
			mix         = r[MIX_W+3:4];
			send_command(CMD_VOL, w);
			vol_set = w;
			hold_and_check("volume_mute", random_sample(), random_sample(),
				random_sample(), random_sample());
			if (w.vol.mute) begin
				check("volume_mute", 0, audio_l);
				check("volume_mute", 0, audio_r);
			end
		end
		end_test("volume_mute");

		send_command(CMD_VOL, '0);
		vol_set = '0;
		for (int m = 0; m < 8; m++) begin
			mix       = m[MIX_W-1:0];
			is_signed = m[MIX_W];
			for (int i = 0; i < N_RAND; i++)
				hold_and_check("mix_clamp", random_sample(), random_sample(),
					random_sample(), random_sample());
			// full scale samples saturate
			hold_and_check("mix_clamp", s_max, s_max, s_max, s_max);
			hold_and_check("mix_clamp", s_min, s_min, s_min, s_min);
			hold_and_check("mix_clamp", '1, s_max, s_max, s_min);
		end
		end_test("mix_clamp");

		for (int g = 0; g < 4; g++) begin
			r         = $urandom;
			mix       = r[MIX_W-1:0];
			is_signed = r[MIX_W];
			hold_and_check("glitch_reject", random_sample(), random_sample(),
				random_sample(), random_sample());
			exp_l = channel_output(core_l, host_l, core_r, host_r, mix, is_signed, vol_set);
			exp_r = channel_output(core_r, host_r, core_l, host_l, mix, is_signed, vol_set);
			a_l   = random_sample();
			a_r   = random_sample();
			// outputs keep the last stable result while the core toggles
			for (int t = 0; t < 20; t++) begin
				@(negedge clk);
				core_l = t[0] ? a_l : ~a_l;
				core_r = t[0] ? a_r : ~a_r;
				check("glitch_reject", exp_l, audio_l);
				check("glitch_reject", exp_r, audio_r);
			end
			@(negedge clk);
			core_l = random_sample();
			core_r = random_sample();
			exp_l  = channel_output(core_l, host_l, core_r, host_r, mix, is_signed, vol_set);
			exp_r  = channel_output(core_r, host_r, core_l, host_l, mix, is_signed, vol_set);
			n = 0;
			while (n < HOLD && (audio_l !== exp_l || audio_r !== exp_r)) begin
				@(negedge clk);
				n++;
			end
			check("glitch_reject", exp_l, audio_l);
			check("glitch_reject", exp_r, audio_r);
		end
		end_test("glitch_reject");

		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
		if (total_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+sim
logic/uio_pkg.sv
logic/audio_pkg.sv
logic/uio_cmd_decoder.sv
logic/sample_deglitch.sv
logic/audio_mix_channel.sv
logic/hps_audio_top.sv
sim/tb_hps_audio.sv
